//--- design/spi_rd_pkg.sv
`default_nettype none

package spi_rd_pkg;

    // Serial clock timing, in system clocks per half-period
    localparam int SCLK_HALF = 2;

    localparam int TX_MAX_BITS = 40;
    localparam int RX_MAX_BITS = 32;

    // Supported read opcodes
    localparam logic [7:0] OP_READ      = 8'h03;
    localparam logic [7:0] OP_FAST_READ = 8'h0B;
    localparam logic [7:0] OP_DUAL_OUT  = 8'h3B;
    localparam logic [7:0] OP_QUAD_OUT  = 8'h6B;
    localparam logic [7:0] OP_QUAD_IO   = 8'hEB;

    // Dummy clocks between address and data
    localparam logic [3:0] FAST_DUMMY = 4'd8;
    localparam logic [3:0] QIO_DUMMY  = 4'd4;

    // Mode byte sent after the address of a quad I/O read, bit 7 confirms XIP
    localparam logic [7:0] MODE_XIP = 8'hA0;

    typedef enum logic [1:0] {
        LANE_1 = 2'd0,
        LANE_2 = 2'd1,
        LANE_4 = 2'd2
    } spi_lane_e;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [23:0] addr;
        logic [2:0]  nbytes;
    } spi_req_t;

    typedef struct packed {
        logic [TX_MAX_BITS-1:0] tx_bits;
        spi_lane_e              cmd_lanes;
        spi_lane_e              addr_lanes;
        logic [5:0]             addr_start;
        logic [5:0]             tx_len;
        logic [3:0]             dummy_cycles;
        logic                   xip_en;
        logic                   xip_bit;
        spi_lane_e              rx_lanes;
        logic [5:0]             rx_bits;
    } spi_frame_t;

    typedef struct packed {
        logic [RX_MAX_BITS-1:0] data;
        logic                   err;
    } spi_resp_t;

endpackage

`default_nettype wire

//--- design/spi_cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_decode (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   req_valid,
    input  wire spi_rd_pkg::spi_req_t   req,
    input  wire logic                   resp_done,
    output logic                        busy,
    output logic                        frame_valid,
    output spi_rd_pkg::spi_frame_t      frame,
    output logic                        err_valid
);

    logic                   busy_q;
    logic                   accept;
    logic                   supported;
    spi_rd_pkg::spi_frame_t next_frame;

    // Busy drops in the cycle the response goes out
    assign busy   = busy_q & ~resp_done;
    assign accept = req_valid & ~busy;

    // Opcode lookup
    always_comb begin
        next_frame              = '0;
        supported               = 1'b1;
        next_frame.tx_bits      = {req.opcode, req.addr, 8'h00};
        next_frame.cmd_lanes    = spi_rd_pkg::LANE_1;
        next_frame.addr_lanes   = spi_rd_pkg::LANE_1;
        next_frame.addr_start   = 6'd8;
        next_frame.tx_len       = 6'd32;
        next_frame.dummy_cycles = 4'd0;
        next_frame.xip_en       = 1'b0;
        next_frame.xip_bit      = 1'b0;
        next_frame.rx_lanes     = spi_rd_pkg::LANE_1;
        next_frame.rx_bits      = {req.nbytes, 3'b000};
        case (req.opcode)
            spi_rd_pkg::OP_READ: begin
                next_frame.dummy_cycles = 4'd0;
            end
            spi_rd_pkg::OP_FAST_READ: begin
                next_frame.dummy_cycles = spi_rd_pkg::FAST_DUMMY;
            end
            spi_rd_pkg::OP_DUAL_OUT: begin
                next_frame.dummy_cycles = spi_rd_pkg::FAST_DUMMY;
                next_frame.rx_lanes     = spi_rd_pkg::LANE_2;
            end
            spi_rd_pkg::OP_QUAD_OUT: begin
                next_frame.dummy_cycles = spi_rd_pkg::FAST_DUMMY;
                next_frame.rx_lanes     = spi_rd_pkg::LANE_4;
            end
            spi_rd_pkg::OP_QUAD_IO: begin
                // Address and mode byte both go out on four lanes
                next_frame.tx_bits[7:0] = spi_rd_pkg::MODE_XIP;
                next_frame.addr_lanes   = spi_rd_pkg::LANE_4;
                next_frame.tx_len       = 6'(spi_rd_pkg::TX_MAX_BITS);
                next_frame.dummy_cycles = spi_rd_pkg::QIO_DUMMY;
                next_frame.xip_en       = 1'b1;
                next_frame.xip_bit      = spi_rd_pkg::MODE_XIP[7];
                next_frame.rx_lanes     = spi_rd_pkg::LANE_4;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q      <= 1'b0;
            frame_valid <= 1'b0;
            err_valid   <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            err_valid   <= 1'b0;
            if (accept) begin
                busy_q      <= 1'b1;
                frame_valid <= supported;
                err_valid   <= ~supported;
            end else if (resp_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            frame <= next_frame;
        end
    end

endmodule

`default_nettype wire

//--- design/spi_sclk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module spi_sclk_gen (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,
    input  wire logic last_edge,
    output logic      sclk,
    output logic      cs_n,
    output logic      launch,
    output logic      sample
);

    logic       active;
    logic       stop_pending;
    logic [3:0] half_cnt;
    logic       half_end;

    assign half_end = half_cnt == 4'(spi_rd_pkg::SCLK_HALF - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active       <= 1'b0;
            stop_pending <= 1'b0;
            half_cnt     <= 4'd0;
            sclk         <= 1'b0;
            cs_n         <= 1'b1;
            launch       <= 1'b0;
            sample       <= 1'b0;
        end else begin
            launch <= 1'b0;
            sample <= 1'b0;
            if (start) begin
                active       <= 1'b1;
                stop_pending <= 1'b0;
                half_cnt     <= 4'd0;
                sclk         <= 1'b0;
                cs_n         <= 1'b0;
                // First bit goes out during the initial low half
                launch       <= 1'b1;
            end else if (active) begin
                if (last_edge) begin
                    stop_pending <= 1'b1;
                end
                if (half_end) begin
                    half_cnt <= 4'd0;
                    if (!sclk) begin
                        sclk   <= 1'b1;
                        sample <= 1'b1;
                    end else if (stop_pending || last_edge) begin
                        // End of the last high half closes the frame
                        sclk   <= 1'b0;
                        cs_n   <= 1'b1;
                        active <= 1'b0;
                    end else begin
                        sclk   <= 1'b0;
                        launch <= 1'b1;
                    end
                end else begin
                    half_cnt <= half_cnt + 4'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/spi_lane_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_lane_shifter (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   frame_valid,
    input  wire spi_rd_pkg::spi_frame_t frame,
    input  wire logic [3:0]             io_in,
    output logic [3:0]                  io_out,
    output logic [3:0]                  io_oe,
    output logic                        sclk,
    output logic                        cs_n,
    output logic                        rx_valid,
    output logic [31:0]                 rx_data,
    output logic [5:0]                  rx_bits
);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_TX,
        PH_DUMMY,
        PH_RX
    } phase_e;

    phase_e                 phase;
    spi_rd_pkg::spi_frame_t frame_q;
    logic [5:0]             tx_cnt;
    logic [5:0]             tx_idx;
    logic [5:0]             rx_cnt;
    logic [3:0]             dummy_left;
    logic [31:0]            rx_sr;
    logic                   launch;
    logic                   sample;
    logic                   last_edge;
    logic                   rx_last;
    logic [2:0]             tx_step;
    logic [2:0]             rx_step;
    spi_rd_pkg::spi_lane_e  tx_lanes;

    function automatic logic [2:0] lane_step(spi_rd_pkg::spi_lane_e lanes);
        case (lanes)
            spi_rd_pkg::LANE_2: lane_step = 3'd2;
            spi_rd_pkg::LANE_4: lane_step = 3'd4;
            default:            lane_step = 3'd1;
        endcase
    endfunction

    spi_sclk_gen u_sclk_gen (
        .clk       (clk),
        .rst       (rst),
        .start     (frame_valid),
        .last_edge (last_edge),
        .sclk      (sclk),
        .cs_n      (cs_n),
        .launch    (launch),
        .sample    (sample)
    );

    // Command lanes until addr_start, address lanes after
    assign tx_lanes = (tx_cnt < frame_q.addr_start) ? frame_q.cmd_lanes : frame_q.addr_lanes;
    assign tx_step  = lane_step(tx_lanes);
    assign tx_idx   = 6'(spi_rd_pkg::TX_MAX_BITS - 1) - tx_cnt;

    assign rx_step   = lane_step(frame_q.rx_lanes);
    assign rx_last   = (rx_cnt + {3'b000, rx_step}) >= frame_q.rx_bits;
    assign last_edge = sample && phase == PH_RX && rx_last;

    assign rx_data = rx_sr;
    assign rx_bits = frame_q.rx_bits;

    always_ff @(posedge clk) begin
        if (frame_valid) begin
            frame_q <= frame;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase      <= PH_IDLE;
            tx_cnt     <= 6'd0;
            rx_cnt     <= 6'd0;
            dummy_left <= 4'd0;
            io_out     <= 4'b0000;
            io_oe      <= 4'b0000;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (frame_valid) begin
                phase      <= PH_TX;
                tx_cnt     <= 6'd0;
                rx_cnt     <= 6'd0;
                dummy_left <= frame.dummy_cycles;
            end else begin
                if (launch) begin
                    case (phase)
                        PH_TX: begin
                            if (tx_cnt == frame_q.tx_len) begin
                                if (dummy_left != 4'd0) begin
                                    // First dummy clock carries the XIP bit on io0
                                    phase      <= PH_DUMMY;
                                    dummy_left <= dummy_left - 4'd1;
                                    io_out     <= {3'b000, frame_q.xip_bit & frame_q.xip_en};
                                    io_oe      <= {3'b000, frame_q.xip_en};
                                end else begin
                                    phase <= PH_RX;
                                    io_oe <= 4'b0000;
                                end
                            end else begin
                                case (tx_lanes)
                                    spi_rd_pkg::LANE_4: begin
                                        io_out <= frame_q.tx_bits[tx_idx -: 4];
                                        io_oe  <= 4'b1111;
                                    end
                                    spi_rd_pkg::LANE_2: begin
                                        io_out <= {2'b00, frame_q.tx_bits[tx_idx -: 2]};
                                        io_oe  <= 4'b0011;
                                    end
                                    default: begin
                                        io_out <= {3'b000, frame_q.tx_bits[tx_idx]};
                                        io_oe  <= 4'b0001;
                                    end
                                endcase
                                tx_cnt <= tx_cnt + {3'b000, tx_step};
                            end
                        end
                        PH_DUMMY: begin
                            io_oe <= 4'b0000;
                            if (dummy_left == 4'd0) begin
                                phase <= PH_RX;
                            end else begin
                                dummy_left <= dummy_left - 4'd1;
                            end
                        end
                        default: begin
                            io_oe <= 4'b0000;
                        end
                    endcase
                end
                if (sample && phase == PH_RX) begin
                    rx_cnt <= rx_cnt + {3'b000, rx_step};
                    if (rx_last) begin
                        phase    <= PH_IDLE;
                        rx_valid <= 1'b1;
                    end
                end
            end
        end
    end

    // Read data, MSB first
    always_ff @(posedge clk) begin
        if (sample && phase == PH_RX) begin
            case (frame_q.rx_lanes)
                spi_rd_pkg::LANE_4: rx_sr <= {rx_sr[27:0], io_in};
                spi_rd_pkg::LANE_2: rx_sr <= {rx_sr[29:0], io_in[1:0]};
                default:            rx_sr <= {rx_sr[30:0], io_in[1]};
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/spi_read_result.sv
`timescale 1ns/1ps
`default_nettype none

module spi_read_result (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        rx_valid,
    input  wire logic [31:0] rx_data,
    input  wire logic [5:0]  rx_bits,
    input  wire logic        err_valid,
    output logic             resp_valid,
    output spi_rd_pkg::spi_resp_t resp
);

    logic [31:0] data_le;

    // First byte on the wire sits highest in rx_data, move it to bits 7:0
    always_comb begin
        case (rx_bits)
            6'd8:    data_le = {24'd0, rx_data[7:0]};
            6'd16:   data_le = {16'd0, rx_data[7:0], rx_data[15:8]};
            6'd24:   data_le = {8'd0, rx_data[7:0], rx_data[15:8], rx_data[23:16]};
            default: data_le = {rx_data[7:0], rx_data[15:8], rx_data[23:16], rx_data[31:24]};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= rx_valid | err_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid || err_valid) begin
            resp.data <= err_valid ? 32'd0 : data_le;
            resp.err  <= err_valid;
        end
    end

endmodule

`default_nettype wire

//--- design/spi_flash_reader.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_reader (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 req_valid,
    input  wire spi_rd_pkg::spi_req_t req,
    output logic                      busy,
    output logic                      resp_valid,
    output spi_rd_pkg::spi_resp_t     resp,
    output logic                      sclk,
    output logic                      cs_n,
    output logic [3:0]                io_out,
    output logic [3:0]                io_oe,
    input  wire logic [3:0]           io_in
);

    logic                   frame_valid;
    spi_rd_pkg::spi_frame_t frame;
    logic                   err_valid;
    logic                   rx_valid;
    logic [31:0]            rx_data;
    logic [5:0]             rx_bits;

    spi_cmd_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req         (req),
        .resp_done   (resp_valid),
        .busy        (busy),
        .frame_valid (frame_valid),
        .frame       (frame),
        .err_valid   (err_valid)
    );

    spi_lane_shifter u_shifter (
        .clk         (clk),
        .rst         (rst),
        .frame_valid (frame_valid),
        .frame       (frame),
        .io_in       (io_in),
        .io_out      (io_out),
        .io_oe       (io_oe),
        .sclk        (sclk),
        .cs_n        (cs_n),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .rx_bits     (rx_bits)
    );

    spi_read_result u_result (
        .clk        (clk),
        .rst        (rst),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_bits    (rx_bits),
        .err_valid  (err_valid),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

`default_nettype wire

//--- verification/spi_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model (
    input  wire logic       sclk,
    input  wire logic       cs_n,
    input  wire logic [3:0] io_out,
    input  wire logic [3:0] io_oe,
    output logic [3:0]      dq_out,
    output logic [3:0]      dq_oe,
    output logic [7:0]      rec_opcode,
    output logic [23:0]     rec_addr,
    output logic            rec_xip
);

    int unsigned edge_cnt = 0;
    int unsigned bit_pos = 0;
    logic        quad_io;
    int unsigned dummy_start;
    int unsigned data_start;
    int unsigned data_width;

    // Frame layout of each read opcode in rising sclk edges
    assign quad_io = rec_opcode == 8'hEB;

    always_comb begin
        dummy_start = quad_io ? 16 : 32;
        case (rec_opcode)
            8'h03:   data_start = dummy_start;
            8'hEB:   data_start = dummy_start + 4;
            default: data_start = dummy_start + 8;
        endcase
        case (rec_opcode)
            8'h3B:        data_width = 2;
            8'h6B, 8'hEB: data_width = 4;
            default:      data_width = 1;
        endcase
    end

    // Byte at address A is A[7:0] ^ 0x5A and goes out MSB first
    function automatic logic read_bit(int unsigned pos);
        logic [7:0] value;
        value = (rec_addr[7:0] + 8'(pos / 8)) ^ 8'h5A;
        value = value << (pos % 8);
        return value[7];
    endfunction

    // Lanes the controller leaves undriven read as low
    always @(posedge sclk or posedge cs_n) begin
        if (cs_n) begin
            edge_cnt = 0;
        end else begin
            if (edge_cnt == 0) begin
                rec_xip <= 1'b0;
            end
            if (edge_cnt < 8) begin
                rec_opcode = {rec_opcode[6:0], io_out[0] & io_oe[0]};
            end else if (quad_io && edge_cnt < 14) begin
                rec_addr = {rec_addr[19:0], io_out & io_oe};
            end else if (!quad_io && edge_cnt < 32) begin
                rec_addr = {rec_addr[22:0], io_out[0] & io_oe[0]};
            end else if (edge_cnt == dummy_start && data_start > dummy_start) begin
                // Controller owns io0 in the first dummy clock
                rec_xip <= io_oe[0] & io_out[0];
            end
            edge_cnt = edge_cnt + 1;
        end
    end

    // Read data changes on falling sclk
    always @(negedge sclk) begin
        if (!cs_n && edge_cnt >= data_start) begin
            if (edge_cnt == data_start) begin
                bit_pos = 0;
            end
            case (data_width)
                4: begin
                    dq_out <= {read_bit(bit_pos), read_bit(bit_pos + 1),
                               read_bit(bit_pos + 2), read_bit(bit_pos + 3)};
                    dq_oe  <= 4'b1111;
                end
                2: begin
                    dq_out <= {2'b00, read_bit(bit_pos), read_bit(bit_pos + 1)};
                    dq_oe  <= 4'b0011;
                end
                default: begin
                    // Single lane answers on io1
                    dq_out <= {2'b00, read_bit(bit_pos), 1'b0};
                    dq_oe  <= 4'b0010;
                end
            endcase
            bit_pos = bit_pos + data_width;
        end else begin
            dq_oe <= 4'b0000;
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_spi_flash_reader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_flash_reader;

    localparam int RESP_TIMEOUT = 2000;
    localparam int IDLE_WATCH   = 400;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    spi_rd_pkg::spi_req_t  req;
    logic                  busy;
    logic                  resp_valid;
    spi_rd_pkg::spi_resp_t resp;
    logic                  sclk;
    logic                  cs_n;
    logic [3:0]            io_out;
    logic [3:0]            io_oe;
    logic [3:0]            io_in;
    logic [3:0]            dq_out;
    logic [3:0]            dq_oe;
    logic [7:0]            rec_opcode;
    logic [23:0]           rec_addr;
    logic                  rec_xip;

    spi_flash_reader DUT (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .busy       (busy),
        .resp_valid (resp_valid),
        .resp       (resp),
        .sclk       (sclk),
        .cs_n       (cs_n),
        .io_out     (io_out),
        .io_oe      (io_oe),
        .io_in      (io_in)
    );

    spi_flash_model flash (
        .sclk       (sclk),
        .cs_n       (cs_n),
        .io_out     (io_out),
        .io_oe      (io_oe),
        .dq_out     (dq_out),
        .dq_oe      (dq_oe),
        .rec_opcode (rec_opcode),
        .rec_addr   (rec_addr),
        .rec_xip    (rec_xip)
    );

    // Flash drives only enabled lanes, and only inside a frame
    assign io_in = dq_oe & dq_out & {4{~cs_n}};

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_resp(input spi_rd_pkg::spi_resp_t got,
                              input spi_rd_pkg::spi_resp_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: resp got data=%h err=%b, expected data=%h err=%b",
                     $time, got.data, got.err, exp.data, exp.err);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_field(input string name, input logic [23:0] got,
                               input logic [23:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // Little-endian bytes A, A+1, ... with the flash data rule
    function automatic logic [31:0] expected_data(logic [23:0] addr, int nbytes);
        logic [31:0] data;
        logic [7:0]  value;
        data = '0;
        for (int k = 0; k < nbytes; k++) begin
            value = (addr[7:0] + 8'(k)) ^ 8'h5A;
            data  = data | (32'(value) << (8 * k));
        end
        return data;
    endfunction

    task automatic issue_req(input logic [7:0] op, input logic [23:0] addr, input int nbytes);
        spi_rd_pkg::spi_req_t r;
        r.opcode = op;
        r.addr   = addr;
        r.nbytes = 3'(nbytes);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic wait_resp();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!resp_valid) begin
            if (cycles == RESP_TIMEOUT) begin
                $display("No resp_valid within %0d clocks, DUT looks stuck", RESP_TIMEOUT);
                stop_run();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic run_read(input logic [7:0] op, input logic [23:0] addr, input int nbytes);
        spi_rd_pkg::spi_resp_t exp;
        exp.data = expected_data(addr, nbytes);
        exp.err  = 1'b0;
        issue_req(op, addr, nbytes);
        wait_resp();
        check_resp(resp, exp);
        check_bit("busy", busy, 1'b0);
        check_field("opcode", 24'(rec_opcode), 24'(op));
        check_field("addr", rec_addr, addr);
    endtask

    task automatic test_single_read();
        for (int n = 1; n <= 4; n++) begin
            run_read(spi_rd_pkg::OP_READ, 24'($urandom), n);
        end
    endtask

    task automatic test_fast_dual();
        for (int n = 1; n <= 4; n++) begin
            run_read(spi_rd_pkg::OP_FAST_READ, 24'($urandom), n);
            run_read(spi_rd_pkg::OP_DUAL_OUT, 24'($urandom), n);
        end
    endtask

    task automatic test_quad();
        for (int n = 1; n <= 4; n++) begin
            run_read(spi_rd_pkg::OP_QUAD_OUT, 24'($urandom), n);
            run_read(spi_rd_pkg::OP_QUAD_IO, 24'($urandom), n);
        end
    endtask

    task automatic test_xip_bit();
        run_read(spi_rd_pkg::OP_QUAD_IO, 24'($urandom), 4);
        check_bit("xip_bit", rec_xip, 1'b1);
        // Quad output has no mode byte, io0 stays released
        run_read(spi_rd_pkg::OP_QUAD_OUT, 24'($urandom), 4);
        check_bit("xip_bit", rec_xip, 1'b0);
    endtask

    task automatic test_bad_opcode();
        spi_rd_pkg::spi_resp_t exp;
        exp.data = '0;
        exp.err  = 1'b1;
        issue_req(8'h9F, 24'($urandom), 4);
        @(negedge clk);
        check_bit("resp_valid", resp_valid, 1'b0);
        check_bit("busy", busy, 1'b1);
        check_bit("cs_n", cs_n, 1'b1);
        @(negedge clk);
        check_bit("resp_valid", resp_valid, 1'b1);
        check_bit("busy", busy, 1'b0);
        check_bit("cs_n", cs_n, 1'b1);
        check_resp(resp, exp);
        repeat (20) begin
            @(negedge clk);
            check_bit("cs_n", cs_n, 1'b1);
        end
    endtask

    task automatic test_busy_ignore();
        logic [23:0]           first_addr;
        spi_rd_pkg::spi_resp_t exp;
        first_addr = 24'($urandom);
        exp.data   = expected_data(first_addr, 2);
        exp.err    = 1'b0;
        issue_req(spi_rd_pkg::OP_FAST_READ, first_addr, 2);
        @(negedge clk);
        check_bit("busy", busy, 1'b1);
        issue_req(spi_rd_pkg::OP_QUAD_OUT, ~first_addr, 4);
        wait_resp();
        check_resp(resp, exp);
        check_field("addr", rec_addr, first_addr);
        repeat (IDLE_WATCH) begin
            @(negedge clk);
            if (resp_valid) begin
                $display("A second response arrived for a request made while busy");
                stop_run();
            end
            check_bit("cs_n", cs_n, 1'b1);
        end
    endtask

    initial begin
        void'($urandom(61));
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_single_read();
        test_fast_dual();
        test_quad();
        test_xip_bit();
        test_bad_opcode();
        test_busy_ignore();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/spi_rd_pkg.sv
design/spi_cmd_decode.sv
design/spi_sclk_gen.sv
design/spi_lane_shifter.sv
design/spi_read_result.sv
design/spi_flash_reader.sv
verification/spi_flash_model.sv
verification/tb_spi_flash_reader.sv

//--- Makefile
TOP = tb_spi_flash_reader

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f files.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^ALL TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
